/* Bender.yml */
package:
  name: memreq

sources:
  - hw/memreq_pkg.sv
  - hw/word_store.sv
  - hw/cmd_decode.sv
  - hw/req_execute.sv
  - hw/resp_result.sv
  - hw/memreq_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/memreq_tb.sv

/* dv/memreq_tb.sv */
`timescale 1ns/100ps
module memreq_tb;
  import memreq_pkg::*;

  localparam int DRIVE_DLY      = 1;
  localparam int NUM_FILL       = 16;
  localparam int NUM_DIRECTED   = 10;
  localparam int NUM_RANDOM     = 200;
  localparam int NUM_FRAMES     = NUM_FILL + NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 400;
  localparam int DRAIN_CYCLES   = 3 * MAX_WORDS * 4 * 8;  // Three long reads at a slow output rate

  logic        mclk, arst_n;
  logic        s_tvalid_i, s_tready_o, s_tlast_i;
  data_byte_t  s_tdata_i;
  logic        m_tvalid_o, m_tready_i, m_tlast_o;
  data_byte_t  m_tdata_o;

  int unsigned seed = 32'hbaaaa3b9;
  int          ready_low_left;
  mem_word_t   mem_model [2**ADDR_BITS];
  data_byte_t  exp_data [$];  // Expected output bytes in order
  logic        exp_last [$];

  tb_clock_gen i_clk_gen (.mclk_o(mclk), .arst_n_o(arst_n));

  memreq_top i_dut (
    .mclk      (mclk),
    .arst_n    (arst_n),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic cmp_byte(input string name, input data_byte_t got, input data_byte_t expected);
    if (got !== expected) begin
      abort_run($sformatf("[FAIL] %s got 0x%02h expected 0x%02h", name, got, expected));
    end
  endtask

  task automatic cmp_last(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected));
    end
  endtask

  // Every byte lane depends on the full address
  function automatic mem_word_t fill_word(input word_addr_t a);
    return {~a, a ^ 8'h5A, a, a ^ 8'hC3};
  endfunction

  task automatic expect_byte(input data_byte_t b, input logic last);
    exp_data.push_back(b);
    exp_last.push_back(last);
  endtask

  // Entered and left just after a rising edge
  task automatic send_byte(input data_byte_t b, input logic last);
    logic accepted;
    accepted = 1'b0;
    if ($urandom_range(3) == 0) begin
      repeat ($urandom_range(3, 1)) begin
        @(posedge mclk);
        #DRIVE_DLY;
      end
    end
    s_tvalid_i = 1'b1;
    s_tdata_i  = b;
    s_tlast_i  = last;
    while (!accepted) begin
      @(negedge mclk);
      accepted = s_tready_o;  // Beat moves on the coming edge
      @(posedge mclk);
      #DRIVE_DLY;
    end
    s_tvalid_i = 1'b0;
  endtask

  task automatic send_header(input logic [7:0] op, input logic [7:0] len_m1,
                             input logic [15:0] addr, input logic last);
    send_byte(op, 1'b0);
    send_byte(len_m1, 1'b0);
    send_byte(addr[15:8], 1'b0);
    send_byte(addr[7:0], last);
  endtask

  task automatic send_write(input logic [15:0] addr, input logic [7:0] len_m1, input logic fill);
    int         n;
    int         i;
    int         b;
    word_addr_t a;
    mem_word_t  w;
    n = int'(len_m1[3:0]) + 1;
    expect_byte(ACK_OK, 1'b1);
    send_header(OP_WRITE, len_m1, addr, 1'b0);
    for (i = 0; i < n; i++) begin
      a = word_addr_t'(addr[7:0] + i);  // Modulo store depth
      w = fill ? fill_word(a) : mem_word_t'($urandom());
      mem_model[a] = w;
      for (b = 0; b < 4; b++) begin
        send_byte(w[8*b +: 8], (i == n - 1) && (b == 3));
      end
    end
  endtask

  task automatic send_read(input logic [15:0] addr, input logic [7:0] len_m1);
    int         n;
    int         i;
    int         b;
    word_addr_t a;
    n = int'(len_m1[3:0]) + 1;
    for (i = 0; i < n; i++) begin
      a = word_addr_t'(addr[7:0] + i);
      for (b = 0; b < 4; b++) begin
        expect_byte(mem_model[a][8*b +: 8], (i == n - 1) && (b == 3));
      end
    end
    send_header(OP_READ, len_m1, addr, 1'b1);
  endtask

  task automatic send_bad(input int trail);
    logic [7:0] op;
    int         t;
    do begin
      op = 8'($urandom());
    end while (op == OP_WRITE || op == OP_READ);
    expect_byte(ACK_BAD, 1'b1);
    send_header(op, 8'($urandom()), 16'($urandom()), trail == 0);
    for (t = 0; t < trail; t++) begin
      send_byte(8'($urandom()), t == trail - 1);
    end
  endtask

  task automatic run_random_frame();
    int          kind;
    logic [15:0] addr;
    logic [7:0]  len;
    kind = $urandom_range(9);
    addr = 16'($urandom());
    len  = 8'($urandom());
    if (kind < 5) begin
      send_write(addr, len, 1'b0);
    end else if (kind < 9) begin
      send_read(addr, len);
    end else begin
      send_bad($urandom_range(6));
    end
  endtask

  // Output back-pressure in bursts of low cycles
  task automatic drive_ready();
    forever begin
      @(posedge mclk);
      #DRIVE_DLY;
      if (ready_low_left != 0) begin
        m_tready_i     = 1'b0;
        ready_low_left = ready_low_left - 1;
      end else if ($urandom_range(2) == 0) begin
        m_tready_i     = 1'b0;
        ready_low_left = $urandom_range(7);
      end else begin
        m_tready_i = 1'b1;
      end
    end
  endtask

  // Sampled mid-cycle ahead of the edge that moves the beat
  always @(negedge mclk) begin
    if (arst_n && m_tvalid_o && m_tready_i) begin
      if (exp_data.size() == 0) begin
        abort_run($sformatf("output byte 0x%02h arrived with no response pending", m_tdata_o));
      end else begin
        cmp_byte("m_tdata_o", m_tdata_o, exp_data.pop_front());
        cmp_last("m_tlast_o", m_tlast_o, exp_last.pop_front());
      end
    end
  end

  initial begin
    repeat (16 + TIMEOUT_CYCLES) @(posedge mclk);
    abort_run($sformatf("timeout after %0d cycles, DUT stopped responding", TIMEOUT_CYCLES));
  end

  initial begin
    logic [15:0] addr;
    logic [7:0]  len;
    int          k;
    void'($urandom(seed));
    s_tvalid_i     = 1'b0;
    s_tlast_i      = 1'b0;
    s_tdata_i      = '0;
    m_tready_i     = 1'b0;
    ready_low_left = 0;
    fork
      drive_ready();
    join_none
    @(posedge arst_n);
    @(posedge mclk);
    #DRIVE_DLY;

    // Known contents everywhere before any read
    for (k = 0; k < NUM_FILL; k++) begin
      send_write(16'(k * 16), 8'd15, 1'b1);
    end
    repeat (2) begin
      addr = 16'($urandom());
      len  = 8'($urandom());
      send_write(addr, len, 1'b0);
      send_read(addr, len);
    end
    send_write(16'h3CFA, 8'hAF, 1'b0);  // Words 250 up to 9
    send_read(16'h81FC, 8'h07);         // Words 252 up to 3
    send_bad(0);
    send_read(16'($urandom()), 8'($urandom()));
    send_bad($urandom_range(6, 1));
    send_read(16'($urandom()), 8'($urandom()));

    for (k = 0; k < NUM_RANDOM; k++) begin
      run_random_frame();
    end

    k = 0;
    while (exp_data.size() != 0 && k < DRAIN_CYCLES) begin
      @(posedge mclk);
      k++;
    end
    repeat (50) @(posedge mclk);  // Room for any stray bytes
    if (exp_data.size() != 0) begin
      abort_run("responses still missing at end of test");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps
module tb_clock_gen (
  output logic mclk_o,
  output logic arst_n_o
);
  localparam real HALF_PERIOD  = 4.0;  // 8 ns mclk
  localparam int  RESET_CYCLES = 16;

  initial begin
    mclk_o = 1'b0;
    forever #HALF_PERIOD mclk_o = ~mclk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge mclk_o);
    #1 arst_n_o = 1'b1;  // Release clear of the edge
  end

endmodule

/* hw/cmd_decode.sv */
`timescale 1ns/100ps
module cmd_decode (
  input  logic                   mclk,
  input  logic                   arst_n,

  input  logic                   s_tvalid_i,
  output logic                   s_tready_o,
  input  logic                   s_tlast_i,
  input  memreq_pkg::data_byte_t s_tdata_i,

  output logic                   hdr_valid_o,
  input  logic                   hdr_ready_i,
  output memreq_pkg::cmd_hdr_u   hdr_o,

  output logic                   wr_valid_o,
  input  logic                   wr_ready_i,
  output memreq_pkg::mem_word_t  wr_word_o
);
  import memreq_pkg::*;

  logic [1:0]           state_q;
  logic [1:0]           byte_cnt_q;
  logic [WCNT_BITS-1:0] words_left_q;  // Write words still to come, minus one
  logic                 rdy_en_q;
  logic                 hdr_valid_q;
  logic                 wr_valid_q;
  cmd_hdr_u             hdr_q;
  mem_word_t            word_q;
  logic                 beat;
  logic                 last_byte;

  // Hold off the host while a header or word sits unaccepted
  assign s_tready_o  = rdy_en_q & ~hdr_valid_q & ~wr_valid_q;
  assign beat        = s_tvalid_i & s_tready_o;
  assign last_byte   = (byte_cnt_q == 2'd3);

  assign hdr_valid_o = hdr_valid_q;
  assign hdr_o       = hdr_q;
  assign wr_valid_o  = wr_valid_q;
  assign wr_word_o   = word_q;

  always_ff @(posedge mclk) begin
    if (beat && state_q == DEC_HDR) begin
      hdr_q.bytes[2'd3 - byte_cnt_q] <= s_tdata_i;  // Opcode lands in byte 3
    end
    if (beat && state_q == DEC_WDATA) begin
      word_q[8*byte_cnt_q +: 8] <= s_tdata_i;  // LSB first
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= DEC_HDR;
      byte_cnt_q   <= 2'd0;
      words_left_q <= '0;
      rdy_en_q     <= 1'b0;
      hdr_valid_q  <= 1'b0;
      wr_valid_q   <= 1'b0;
    end else begin
      rdy_en_q <= 1'b1;
      if (hdr_valid_q && hdr_ready_i) begin
        hdr_valid_q <= 1'b0;
      end
      if (wr_valid_q && wr_ready_i) begin
        wr_valid_q <= 1'b0;
      end
      if (beat) begin
        case (state_q)
          DEC_HDR: begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (last_byte) begin
              hdr_valid_q <= 1'b1;  // Passed on even for a bad opcode
              if (hdr_q.f.opcode == OP_WRITE) begin
                words_left_q <= hdr_q.f.len_m1[WCNT_BITS-1:0];
                state_q      <= DEC_WDATA;
              end else if (hdr_q.f.opcode != OP_READ && !s_tlast_i) begin
                state_q <= DEC_DISCARD;
              end
            end
          end
          DEC_WDATA: begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (last_byte) begin
              wr_valid_q   <= 1'b1;
              words_left_q <= words_left_q - 1'b1;
              if (words_left_q == '0) begin
                state_q <= DEC_HDR;
              end
            end
          end
          DEC_DISCARD: begin
            if (s_tlast_i) begin
              state_q <= DEC_HDR;  // Drop through end of frame
            end
          end
          default: state_q <= DEC_HDR;
        endcase
      end
    end
  end

  // Header must not change under the executor while it is offered
  hdr_stable_a: assert property (@(posedge mclk) disable iff (!arst_n)
    hdr_valid_o && !hdr_ready_i |=> $stable(hdr_o));

endmodule

/* hw/memreq_pkg.sv */
package memreq_pkg;

  // Store geometry and request limits
  localparam int ADDR_BITS      = 8;
  localparam int MAX_WORDS      = 16;
  localparam int RD_LATENCY     = 2;
  localparam int RES_FIFO_DEPTH = 4;

  // Derived counter widths
  localparam int WCNT_BITS     = $clog2(MAX_WORDS);
  localparam int PTR_BITS      = $clog2(RES_FIFO_DEPTH);
  localparam int CREDIT_BITS   = $clog2(RES_FIFO_DEPTH) + 1;  // Holds 0..DEPTH
  localparam int INFLIGHT_BITS = $clog2(RD_LATENCY + 1);

  // Opcodes and reply bytes
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;
  localparam logic [7:0] ACK_OK   = 8'h00;
  localparam logic [7:0] ACK_BAD  = 8'hFF;

  // Decoder states
  localparam logic [1:0] DEC_HDR     = 2'd0;
  localparam logic [1:0] DEC_WDATA   = 2'd1;
  localparam logic [1:0] DEC_DISCARD = 2'd2;

  // Executor states
  localparam logic [1:0] EXE_IDLE  = 2'd0;
  localparam logic [1:0] EXE_WRITE = 2'd1;
  localparam logic [1:0] EXE_READ  = 2'd2;
  localparam logic [1:0] EXE_STAT  = 2'd3;

  typedef logic [7:0]           data_byte_t;
  typedef logic [31:0]          mem_word_t;
  typedef logic [ADDR_BITS-1:0] word_addr_t;

  // Command header with byte 3 arriving first on the stream
  typedef union packed {
    data_byte_t [3:0] bytes;
    struct packed {
      logic [7:0]  opcode;
      logic [7:0]  len_m1;  // Words minus one
      logic [15:0] addr;
    } f;
  } cmd_hdr_u;

endpackage

/* hw/memreq_top.sv */
`timescale 1ns/100ps
module memreq_top (
  input  logic                   mclk,
  input  logic                   arst_n,

  // Host command stream
  input  logic                   s_tvalid_i,
  output logic                   s_tready_o,
  input  logic                   s_tlast_i,
  input  memreq_pkg::data_byte_t s_tdata_i,

  // Response stream
  output logic                   m_tvalid_o,
  input  logic                   m_tready_i,
  output logic                   m_tlast_o,
  output memreq_pkg::data_byte_t m_tdata_o
);
  import memreq_pkg::*;

  logic       hdr_valid, hdr_ready;
  cmd_hdr_u   hdr;
  logic       wr_valid, wr_ready;
  mem_word_t  wr_word;

  logic       wr_en, rd_en;
  word_addr_t addr;
  mem_word_t  wdata;
  logic       rd_data_valid;
  mem_word_t  rd_data;

  logic       word_valid, word_last, word_pop;
  mem_word_t  word;
  logic       stat_valid, stat_ready;
  data_byte_t stat_byte;

  cmd_decode u_decode (
    .mclk       (mclk),
    .arst_n     (arst_n),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .s_tlast_i  (s_tlast_i),
    .s_tdata_i  (s_tdata_i),
    .hdr_valid_o(hdr_valid),
    .hdr_ready_i(hdr_ready),
    .hdr_o      (hdr),
    .wr_valid_o (wr_valid),
    .wr_ready_i (wr_ready),
    .wr_word_o  (wr_word)
  );

  req_execute u_execute (
    .mclk           (mclk),
    .arst_n         (arst_n),
    .hdr_valid_i    (hdr_valid),
    .hdr_ready_o    (hdr_ready),
    .hdr_i          (hdr),
    .wr_valid_i     (wr_valid),
    .wr_ready_o     (wr_ready),
    .wr_word_i      (wr_word),
    .wr_en_o        (wr_en),
    .rd_en_o        (rd_en),
    .addr_o         (addr),
    .wdata_o        (wdata),
    .rd_data_valid_i(rd_data_valid),
    .rd_data_i      (rd_data),
    .word_valid_o   (word_valid),
    .word_o         (word),
    .word_last_o    (word_last),
    .word_pop_i     (word_pop),
    .stat_valid_o   (stat_valid),
    .stat_ready_i   (stat_ready),
    .stat_byte_o    (stat_byte)
  );

  // Stands in for the DDR3 controller
  word_store u_store (
    .mclk           (mclk),
    .wr_en_i        (wr_en),
    .rd_en_i        (rd_en),
    .addr_i         (addr),
    .wdata_i        (wdata),
    .rd_data_valid_o(rd_data_valid),
    .rd_data_o      (rd_data)
  );

  resp_result u_result (
    .mclk        (mclk),
    .arst_n      (arst_n),
    .word_valid_i(word_valid),
    .word_i      (word),
    .word_last_i (word_last),
    .word_pop_o  (word_pop),
    .stat_valid_i(stat_valid),
    .stat_ready_o(stat_ready),
    .stat_byte_i (stat_byte),
    .m_tvalid_o  (m_tvalid_o),
    .m_tready_i  (m_tready_i),
    .m_tlast_o   (m_tlast_o),
    .m_tdata_o   (m_tdata_o)
  );

endmodule

/* hw/req_execute.sv */
`timescale 1ns/100ps
module req_execute (
  input  logic                   mclk,
  input  logic                   arst_n,

  input  logic                   hdr_valid_i,
  output logic                   hdr_ready_o,
  input  memreq_pkg::cmd_hdr_u   hdr_i,
  input  logic                   wr_valid_i,
  output logic                   wr_ready_o,
  input  memreq_pkg::mem_word_t  wr_word_i,

  output logic                   wr_en_o,
  output logic                   rd_en_o,
  output memreq_pkg::word_addr_t addr_o,
  output memreq_pkg::mem_word_t  wdata_o,
  input  logic                   rd_data_valid_i,
  input  memreq_pkg::mem_word_t  rd_data_i,

  output logic                   word_valid_o,
  output memreq_pkg::mem_word_t  word_o,
  output logic                   word_last_o,
  input  logic                   word_pop_i,
  output logic                   stat_valid_o,
  input  logic                   stat_ready_i,
  output memreq_pkg::data_byte_t stat_byte_o
);
  import memreq_pkg::*;

  logic [1:0]               state_q;
  word_addr_t               addr_q;
  data_byte_t               stat_q;
  logic [WCNT_BITS-1:0]     left_q;      // Words remaining, minus one
  logic [CREDIT_BITS-1:0]   credits_q;   // Free result FIFO slots
  logic [INFLIGHT_BITS-1:0] inflight_q;  // Reads issued, data not back yet
  logic [RD_LATENCY-1:0]    last_pipe_q;
  logic                     step;
  logic                     final_word;

  assign hdr_ready_o = (state_q == EXE_IDLE);
  assign wr_ready_o  = (state_q == EXE_WRITE);
  assign wr_en_o     = wr_valid_i & wr_ready_o;
  assign rd_en_o     = (state_q == EXE_READ) && (credits_q != '0);
  assign addr_o      = addr_q;
  assign wdata_o     = wr_word_i;
  assign step        = wr_en_o | rd_en_o;
  assign final_word  = (left_q == '0);

  assign word_valid_o = rd_data_valid_i;
  assign word_o       = rd_data_i;
  assign word_last_o  = last_pipe_q[RD_LATENCY-1];  // Lines up with store data

  // Reply only once earlier read data has reached the result FIFO
  assign stat_valid_o = (state_q == EXE_STAT) && (inflight_q == '0);
  assign stat_byte_o  = stat_q;

  always_ff @(posedge mclk) begin
    if (hdr_valid_i && hdr_ready_o) begin
      addr_q <= hdr_i.f.addr[ADDR_BITS-1:0];
      stat_q <= (hdr_i.f.opcode == OP_WRITE) ? ACK_OK : ACK_BAD;
    end else if (step) begin
      addr_q <= addr_q + 1'b1;  // Wraps at store depth
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= EXE_IDLE;
      left_q      <= '0;
      credits_q   <= CREDIT_BITS'(RES_FIFO_DEPTH);
      inflight_q  <= '0;
      last_pipe_q <= '0;
    end else begin
      credits_q   <= credits_q - CREDIT_BITS'(rd_en_o) + CREDIT_BITS'(word_pop_i);
      inflight_q  <= inflight_q + INFLIGHT_BITS'(rd_en_o) - INFLIGHT_BITS'(rd_data_valid_i);
      last_pipe_q <= {last_pipe_q[RD_LATENCY-2:0], rd_en_o & final_word};
      case (state_q)
        EXE_IDLE: begin
          if (hdr_valid_i) begin
            left_q <= hdr_i.f.len_m1[WCNT_BITS-1:0];
            case (hdr_i.f.opcode)
              OP_WRITE: state_q <= EXE_WRITE;
              OP_READ:  state_q <= EXE_READ;
              default:  state_q <= EXE_STAT;  // Straight to ACK_BAD
            endcase
          end
        end
        EXE_WRITE, EXE_READ: begin
          if (step) begin
            left_q <= left_q - 1'b1;
            if (final_word) begin
              state_q <= (state_q == EXE_WRITE) ? EXE_STAT : EXE_IDLE;
            end
          end
        end
        default: begin
          if (stat_valid_o && stat_ready_i) begin
            state_q <= EXE_IDLE;
          end
        end
      endcase
    end
  end

  // Pops from the result stage must never push credits past the FIFO size
  credit_range_a: assert property (@(posedge mclk) disable iff (!arst_n)
    credits_q <= CREDIT_BITS'(RES_FIFO_DEPTH));

  store_excl_a: assert property (@(posedge mclk) disable iff (!arst_n)
    !(wr_en_o && rd_en_o));

endmodule

/* hw/resp_result.sv */
`timescale 1ns/100ps
module resp_result (
  input  logic                   mclk,
  input  logic                   arst_n,

  input  logic                   word_valid_i,
  input  memreq_pkg::mem_word_t  word_i,
  input  logic                   word_last_i,
  output logic                   word_pop_o,
  input  logic                   stat_valid_i,
  output logic                   stat_ready_o,
  input  memreq_pkg::data_byte_t stat_byte_i,

  output logic                   m_tvalid_o,
  input  logic                   m_tready_i,
  output logic                   m_tlast_o,
  output memreq_pkg::data_byte_t m_tdata_o
);
  import memreq_pkg::*;

  mem_word_t               fifo_q [RES_FIFO_DEPTH];
  logic [RES_FIFO_DEPTH-1:0] last_q;
  logic [PTR_BITS-1:0]     wr_ptr_q, rd_ptr_q;
  logic [CREDIT_BITS-1:0]  count_q;
  logic [1:0]              byte_idx_q;  // Next byte of head word
  logic                    fifo_empty;
  logic                    word_beat;
  mem_word_t               head_word;

  assign fifo_empty = (count_q == '0);
  assign head_word  = fifo_q[rd_ptr_q];
  assign word_beat  = ~fifo_empty & m_tready_i;
  assign word_pop_o = word_beat & (byte_idx_q == 2'd3);

  // Status bytes only go out with no read data pending
  assign stat_ready_o = fifo_empty & m_tready_i;

  assign m_tvalid_o = ~fifo_empty | stat_valid_i;
  assign m_tdata_o  = fifo_empty ? stat_byte_i : head_word[8*byte_idx_q +: 8];
  assign m_tlast_o  = fifo_empty | (last_q[rd_ptr_q] & (byte_idx_q == 2'd3));

  always_ff @(posedge mclk) begin
    if (word_valid_i) begin
      fifo_q[wr_ptr_q] <= word_i;
      last_q[wr_ptr_q] <= word_last_i;
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      byte_idx_q <= 2'd0;
    end else begin
      if (word_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (word_beat) begin
        byte_idx_q <= byte_idx_q + 2'd1;  // Wraps after byte 3
      end
      if (word_pop_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CREDIT_BITS'(word_valid_i) - CREDIT_BITS'(word_pop_o);
    end
  end

  // Executor credits should keep every push within the FIFO
  no_overflow_a: assert property (@(posedge mclk) disable iff (!arst_n)
    word_valid_i |-> count_q < CREDIT_BITS'(RES_FIFO_DEPTH));

endmodule

/* hw/word_store.sv */
`timescale 1ns/100ps
module word_store (
  input  logic                   mclk,
  input  logic                   wr_en_i,
  input  logic                   rd_en_i,
  input  memreq_pkg::word_addr_t addr_i,
  input  memreq_pkg::mem_word_t  wdata_i,
  output logic                   rd_data_valid_o,
  output memreq_pkg::mem_word_t  rd_data_o
);
  import memreq_pkg::*;

  mem_word_t             mem_q [2**ADDR_BITS];
  mem_word_t             data_pipe_q [RD_LATENCY];
  logic [RD_LATENCY-1:0] vld_pipe_q;

  assign rd_data_valid_o = vld_pipe_q[RD_LATENCY-1];
  assign rd_data_o       = data_pipe_q[RD_LATENCY-1];

  always_ff @(posedge mclk) begin
    if (wr_en_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Registered array read, then output register
  always_ff @(posedge mclk) begin
    vld_pipe_q[0] <= rd_en_i;
    if (rd_en_i) begin
      data_pipe_q[0] <= mem_q[addr_i];
    end
    for (int i = 1; i < RD_LATENCY; i++) begin
      vld_pipe_q[i]  <= vld_pipe_q[i-1];
      data_pipe_q[i] <= data_pipe_q[i-1];
    end
  end

endmodule

/* list.f */
hw/memreq_pkg.sv
hw/word_store.sv
hw/cmd_decode.sv
hw/req_execute.sv
hw/resp_result.sv
hw/memreq_top.sv
dv/tb_clock_gen.sv
dv/memreq_tb.sv
